// ==== Bender.yml ====
package:
  name: read_cache

sources:
  # Shared package first
  - common/cache_pkg.sv
  # Set storage and hit logic
  - cache_set/cache_mem.sv
  - cache_set/cache_set.sv
  # Pipeline stages and top level
  - src/cache_req_stage.sv
  - src/cache_ctrl.sv
  - src/cache_top.sv
  # Testbench and bound checker
  - target: test
    files:
      - verification/cache_chk.sv
      - verification/cache_tb.sv

// ==== cache_set/cache_mem.sv ====
// ------------------------------------------------------------
// Word array with clocked write and asynchronous read
// ------------------------------------------------------------

`timescale 1ns/10ps

module cache_mem #(
    parameter int unsigned DATA_WIDTH = 32,     // Word width in bits
    parameter int unsigned ADDR_WIDTH = 4       // Address width in bits
) (
    input  logic                  i_clock,      // Clock
    input  logic                  i_we,         // Write enable
    input  logic [ADDR_WIDTH-1:0] i_addr,       // Read and write address
    input  logic [DATA_WIDTH-1:0] i_wdata,      // Word to store
    output logic [DATA_WIDTH-1:0] o_rdata       // Word at i_addr
);

    localparam int unsigned DEPTH = 2**ADDR_WIDTH;  // Number of words

    logic [DATA_WIDTH-1:0] mem [DEPTH];         // Storage, contents undefined at start

    // ------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;             // Stored at the edge
        end
    end

    // ------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------

    // Read is combinational, so a write shows up one cycle later
    assign o_rdata = mem[i_addr];

endmodule

// ==== cache_set/cache_set.sv ====
// ------------------------------------------------------------
// Direct-mapped set: data memory, valid/tag memory and the
// tag compare that produces the hit flag
// ------------------------------------------------------------

`timescale 1ns/10ps

module cache_set #(
    parameter int unsigned DATA_WIDTH   = 32,   // Data word width
    parameter int unsigned TAG_WIDTH    = 8,    // Tag width
    parameter int unsigned INDEX_WIDTH  = 4,    // Line index width
    parameter int unsigned OFFSET_WIDTH = 2     // Word offset width inside a block
) (
    input  logic                    i_clock,    // Clock
    input  logic                    i_rst_n,    // Sync reset, active low
    input  logic                    i_write,    // Store word, mark line valid
    input  logic                    i_clear,    // Mark line invalid
    input  logic [TAG_WIDTH-1:0]    i_tag,      // Tag to store or compare
    input  logic [INDEX_WIDTH-1:0]  i_index,    // Line select
    input  logic [OFFSET_WIDTH-1:0] i_offset,   // Word select inside the line
    input  logic [DATA_WIDTH-1:0]   i_wdata,    // Refill word
    output logic [DATA_WIDTH-1:0]   o_rdata,    // Word at index/offset
    output logic                    o_hit       // Line valid and tag matches
);

    typedef struct packed {
        logic                 valid;            // Line holds data
        logic [TAG_WIDTH-1:0] tag;              // Upper address bits of the line
    } meta_t;

    logic  data_we;                             // Data memory write enable
    logic  meta_we;                             // Metadata memory write enable
    meta_t meta_wdata;                          // Metadata to store
    meta_t meta_rdata;                          // Metadata of the selected line

    // ------------------------------------------------------------
    // Write control
    // ------------------------------------------------------------

    assign data_we = i_write & ~i_clear;        // Clear never touches data
    assign meta_we = i_write | i_clear;

    // Clear wins over write, leaving an invalid line with a zero tag
    assign meta_wdata.valid = ~i_clear;
    assign meta_wdata.tag   = i_clear ? '0 : i_tag;

    // Hit is masked during reset and any update of the line
    assign o_hit = meta_rdata.valid & (meta_rdata.tag == i_tag)
                 & i_rst_n & ~i_write & ~i_clear;

    // ------------------------------------------------------------
    // Data memory, one word per index and offset
    // ------------------------------------------------------------

    cache_mem #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (INDEX_WIDTH + OFFSET_WIDTH)
    ) u_data_mem (
        .i_clock (i_clock),
        .i_we    (data_we),
        .i_addr  ({i_index, i_offset}),
        .i_wdata (i_wdata),
        .o_rdata (o_rdata)
    );

    // ------------------------------------------------------------
    // Metadata memory, one entry per line
    // ------------------------------------------------------------

    cache_mem #(
        .DATA_WIDTH ($bits(meta_t)),
        .ADDR_WIDTH (INDEX_WIDTH)
    ) u_meta_mem (
        .i_clock (i_clock),
        .i_we    (meta_we),
        .i_addr  (i_index),
        .i_wdata (meta_wdata),
        .o_rdata (meta_rdata)
    );

endmodule

// ==== common/cache_pkg.sv ====
// ------------------------------------------------------------
// Shared enums of the read cache: request opcodes and
// controller FSM states
// ------------------------------------------------------------

package cache_pkg;

    // ------------------------------------------------------------
    // Request opcodes
    // ------------------------------------------------------------

    typedef enum logic {
        OP_READ  = 1'b0,        // Return one word
        OP_INVAL = 1'b1         // Drop the selected line
    } cache_op_e;

    // ------------------------------------------------------------
    // Controller states
    // ------------------------------------------------------------

    typedef enum logic [1:0] {
        ST_SWEEP     = 2'd0,    // Clearing all lines after reset
        ST_IDLE      = 2'd1,    // Serving hits and invalidates
        ST_FILL_REQ  = 2'd2,    // Issue one memory read
        ST_FILL_WAIT = 2'd3     // Wait for the memory word
    } ctrl_state_e;

endpackage

// ==== list.f ====
common/cache_pkg.sv
cache_set/cache_mem.sv
cache_set/cache_set.sv
src/cache_req_stage.sv
src/cache_ctrl.sv
src/cache_top.sv
verification/cache_chk.sv
verification/cache_tb.sv

// ==== src/cache_ctrl.sv ====
// ------------------------------------------------------------
// Stage two: hit check, block refill, invalidate, reset sweep
// and read response register
// ------------------------------------------------------------

`timescale 1ns/10ps

module cache_ctrl
    import cache_pkg::*;
#(
    parameter int unsigned DATA_WIDTH   = 32,   // Data word width
    parameter int unsigned TAG_WIDTH    = 8,    // Tag width
    parameter int unsigned INDEX_WIDTH  = 4,    // Line index width
    parameter int unsigned OFFSET_WIDTH = 2     // Word offset width
) (
    input  logic                    i_clock,        // Clock
    input  logic                    i_rst_n,        // Sync reset, active low
    input  logic                    i_valid,        // Stage one holds a request
    input  cache_op_e               i_op,           // Stage one opcode
    input  logic [TAG_WIDTH-1:0]    i_tag,          // Stage one tag
    input  logic [INDEX_WIDTH-1:0]  i_index,        // Stage one index
    input  logic [OFFSET_WIDTH-1:0] i_offset,       // Stage one offset
    input  logic                    i_hit,          // Set hit flag
    input  logic [DATA_WIDTH-1:0]   i_set_rdata,    // Set read word
    input  logic                    i_mem_valid,    // Memory word strobe
    input  logic [DATA_WIDTH-1:0]   i_mem_rdata,    // Memory word
    output logic                    o_stall,        // Hold stage one
    output logic                    o_busy,         // Requester must wait
    output logic                    o_set_write,    // Store refill word
    output logic                    o_set_clear,    // Invalidate line
    output logic [INDEX_WIDTH-1:0]  o_set_index,    // Set line select
    output logic [OFFSET_WIDTH-1:0] o_set_offset,   // Set word select
    output logic [DATA_WIDTH-1:0]   o_set_wdata,    // Refill word to the set
    output logic                    o_mem_rd,       // Memory read strobe
    output logic [TAG_WIDTH+INDEX_WIDTH+OFFSET_WIDTH-1:0] o_mem_addr,  // Memory word address
    output logic                    o_rvalid,       // Read response strobe
    output logic [DATA_WIDTH-1:0]   o_rdata         // Read response word
);

    localparam int unsigned LAST_LINE = 2**INDEX_WIDTH - 1;    // Final sweep line
    localparam int unsigned LAST_WORD = 2**OFFSET_WIDTH - 1;   // Final word of a block

    ctrl_state_e             state_q;           // Current FSM state
    ctrl_state_e             state_d;           // Next FSM state
    logic [INDEX_WIDTH-1:0]  sweep_cnt;         // Line being cleared
    logic [OFFSET_WIDTH-1:0] fill_cnt;          // Block word being fetched
    logic                    rd_req;            // Read waiting in stage one, FSM idle
    logic                    read_hit;
    logic                    read_miss;

    // ------------------------------------------------------------
    // Request decode
    // ------------------------------------------------------------

    assign rd_req    = (state_q == ST_IDLE) & i_valid & (i_op == OP_READ);
    assign read_hit  = rd_req & i_hit;
    assign read_miss = rd_req & ~i_hit;

    // Stage one freezes while a miss sits there or the FSM is away from idle
    assign o_stall = (state_q != ST_IDLE) | read_miss;
    assign o_busy  = o_stall;                   // Nothing queued, so same condition

    // ------------------------------------------------------------
    // FSM next state
    // ------------------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_SWEEP: begin
                if (sweep_cnt == INDEX_WIDTH'(LAST_LINE)) begin
                    state_d = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (read_miss) begin
                    state_d = ST_FILL_REQ;  // Fetch from the block base
                end
            end
            ST_FILL_REQ: state_d = ST_FILL_WAIT;  // One-cycle strobe
            ST_FILL_WAIT: begin
                if (i_mem_valid) begin
                    // Back to idle replays the held request as a hit
                    state_d = (fill_cnt == OFFSET_WIDTH'(LAST_WORD)) ? ST_IDLE : ST_FILL_REQ;
                end
            end
        endcase
    end

    // ------------------------------------------------------------
    // State, counters and response strobe
    // ------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state_q   <= ST_SWEEP;
            sweep_cnt <= '0;
            fill_cnt  <= '0;
            o_rvalid  <= 1'b0;
        end else begin
            state_q  <= state_d;
            o_rvalid <= read_hit;
            if (state_q == ST_SWEEP) begin
                sweep_cnt <= sweep_cnt + 1'b1;  // Wraps to zero at the end
            end
            if (state_q == ST_FILL_WAIT && i_mem_valid) begin
                fill_cnt <= fill_cnt + 1'b1;    // Wraps to zero after last word
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (read_hit) begin
            o_rdata <= i_set_rdata;             // Held until the next hit
        end
    end

    // ------------------------------------------------------------
    // Set steering
    // ------------------------------------------------------------

    always_comb begin
        o_set_write  = 1'b0;
        o_set_clear  = 1'b0;
        o_set_index  = i_index;                 // Default is the stage one request
        o_set_offset = i_offset;
        case (state_q)
            ST_SWEEP: begin
                o_set_clear  = 1'b1;
                o_set_index  = sweep_cnt;
                o_set_offset = '0;
            end
            ST_IDLE: begin
                o_set_clear = i_valid & (i_op == OP_INVAL);  // Same cycle, no stall
            end
            ST_FILL_REQ: begin
                o_set_offset = fill_cnt;
            end
            ST_FILL_WAIT: begin
                o_set_write  = i_mem_valid;     // Word, tag and valid together
                o_set_offset = fill_cnt;
            end
        endcase
    end

    assign o_set_wdata = i_mem_rdata;

    // Memory side
    assign o_mem_rd   = (state_q == ST_FILL_REQ);
    assign o_mem_addr = {i_tag, i_index, fill_cnt};

endmodule

// ==== src/cache_req_stage.sv ====
// ------------------------------------------------------------
// Stage one: request register with address split
// ------------------------------------------------------------

`timescale 1ns/10ps

module cache_req_stage
    import cache_pkg::*;
#(
    parameter int unsigned DATA_WIDTH   = 32,   // Data word width
    parameter int unsigned TAG_WIDTH    = 8,    // Tag width
    parameter int unsigned INDEX_WIDTH  = 4,    // Line index width
    parameter int unsigned OFFSET_WIDTH = 2     // Word offset width
) (
    input  logic                    i_clock,    // Clock
    input  logic                    i_rst_n,    // Sync reset, active low
    input  logic                    i_req,      // Request strobe
    input  cache_op_e               i_op,       // Request opcode
    input  logic [TAG_WIDTH+INDEX_WIDTH+OFFSET_WIDTH-1:0] i_addr,  // Word address
    input  logic                    i_stall,    // Hold current request
    output logic                    o_valid,    // Stage holds a request
    output cache_op_e               o_op,       // Held opcode
    output logic [TAG_WIDTH-1:0]    o_tag,      // Address tag field
    output logic [INDEX_WIDTH-1:0]  o_index,    // Address index field
    output logic [OFFSET_WIDTH-1:0] o_offset    // Address offset field
);

    localparam int unsigned ADDR_WIDTH = TAG_WIDTH + INDEX_WIDTH + OFFSET_WIDTH;

    logic [ADDR_WIDTH-1:0] addr_q;              // Registered word address

    // ------------------------------------------------------------
    // Valid flag
    // ------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else if (!i_stall) begin
            o_valid <= i_req;                   // Empties when no new request
        end
    end

    // Payload, loaded only on a fresh request
    always_ff @(posedge i_clock) begin
        if (!i_stall && i_req) begin
            o_op   <= i_op;
            addr_q <= i_addr;
        end
    end

    // Tag | index | offset, MSB first
    assign o_tag    = addr_q[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign o_index  = addr_q[OFFSET_WIDTH +: INDEX_WIDTH];
    assign o_offset = addr_q[OFFSET_WIDTH-1:0];

endmodule

// ==== src/cache_top.sv ====
// ------------------------------------------------------------
// Read cache top level: request stage, controller and set
// ------------------------------------------------------------

`timescale 1ns/10ps

module cache_top
    import cache_pkg::*;
#(
    parameter int unsigned DATA_WIDTH   = 32,   // Data word width
    parameter int unsigned TAG_WIDTH    = 8,    // Tag width
    parameter int unsigned INDEX_WIDTH  = 4,    // 16 lines
    parameter int unsigned OFFSET_WIDTH = 2     // 4 words per block
) (
    input  logic                  i_clock,      // Clock
    input  logic                  i_rst_n,      // Sync reset, active low
    input  logic                  i_req,        // Request strobe
    input  cache_op_e             i_op,         // Request opcode
    input  logic [TAG_WIDTH+INDEX_WIDTH+OFFSET_WIDTH-1:0] i_addr,      // Word address
    input  logic                  i_mem_valid,  // Memory word strobe
    input  logic [DATA_WIDTH-1:0] i_mem_rdata,  // Memory word
    output logic                  o_busy,       // Requester must not strobe
    output logic                  o_valid,      // Read response strobe
    output logic [DATA_WIDTH-1:0] o_rdata,      // Read response word
    output logic                  o_mem_rd,     // Memory read strobe
    output logic [TAG_WIDTH+INDEX_WIDTH+OFFSET_WIDTH-1:0] o_mem_addr   // Memory word address
);

    // Stage one to controller
    logic                    s1_valid;
    cache_op_e               s1_op;
    logic [TAG_WIDTH-1:0]    s1_tag;            // Also the set compare tag
    logic [INDEX_WIDTH-1:0]  s1_index;
    logic [OFFSET_WIDTH-1:0] s1_offset;
    logic                    stall;

    // Controller to set
    logic                    set_write;
    logic                    set_clear;
    logic [INDEX_WIDTH-1:0]  set_index;
    logic [OFFSET_WIDTH-1:0] set_offset;
    logic [DATA_WIDTH-1:0]   set_wdata;
    logic                    set_hit;
    logic [DATA_WIDTH-1:0]   set_rdata;

    cache_req_stage #(
        .DATA_WIDTH (DATA_WIDTH), .TAG_WIDTH (TAG_WIDTH),
        .INDEX_WIDTH (INDEX_WIDTH), .OFFSET_WIDTH (OFFSET_WIDTH)
    ) u_req_stage (
        .i_clock (i_clock), .i_rst_n (i_rst_n), .i_req (i_req), .i_op (i_op),
        .i_addr (i_addr), .i_stall (stall), .o_valid (s1_valid), .o_op (s1_op),
        .o_tag (s1_tag), .o_index (s1_index), .o_offset (s1_offset)
    );

    cache_ctrl #(
        .DATA_WIDTH (DATA_WIDTH), .TAG_WIDTH (TAG_WIDTH),
        .INDEX_WIDTH (INDEX_WIDTH), .OFFSET_WIDTH (OFFSET_WIDTH)
    ) u_ctrl (
        .i_clock (i_clock), .i_rst_n (i_rst_n), .i_valid (s1_valid), .i_op (s1_op),
        .i_tag (s1_tag), .i_index (s1_index), .i_offset (s1_offset), .i_hit (set_hit),
        .i_set_rdata (set_rdata), .i_mem_valid (i_mem_valid), .i_mem_rdata (i_mem_rdata),
        .o_stall (stall), .o_busy (o_busy), .o_set_write (set_write),
        .o_set_clear (set_clear), .o_set_index (set_index), .o_set_offset (set_offset),
        .o_set_wdata (set_wdata), .o_mem_rd (o_mem_rd), .o_mem_addr (o_mem_addr),
        .o_rvalid (o_valid), .o_rdata (o_rdata)
    );

    cache_set #(
        .DATA_WIDTH (DATA_WIDTH), .TAG_WIDTH (TAG_WIDTH),
        .INDEX_WIDTH (INDEX_WIDTH), .OFFSET_WIDTH (OFFSET_WIDTH)
    ) u_set (
        .i_clock (i_clock), .i_rst_n (i_rst_n), .i_write (set_write),
        .i_clear (set_clear), .i_tag (s1_tag), .i_index (set_index),
        .i_offset (set_offset), .i_wdata (set_wdata), .o_rdata (set_rdata),
        .o_hit (set_hit)
    );

endmodule

// ==== verification/cache_chk.sv ====
// ------------------------------------------------------------
// Protocol assertions on the cache top level ports
// ------------------------------------------------------------

`timescale 1ns/10ps

module cache_chk
    import cache_pkg::*;
(
    input logic        i_clock,                 // Clock
    input logic        i_rst_n,                 // Sync reset, active low
    input logic        i_req,                   // Request strobe
    input logic        i_busy,                  // Cache busy level
    input logic        i_valid,                 // Read response strobe
    input logic        i_mem_rd,                // Memory read strobe
    input logic        i_mem_valid,             // Memory word strobe
    input ctrl_state_e i_state                  // Controller FSM state
);

    logic        rd_pending;                    // Memory read issued, word not back yet
    int unsigned fail_count = 0;                // Assertion failures so far

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            rd_pending <= 1'b0;
        end else if (i_mem_rd) begin
            rd_pending <= 1'b1;
        end else if (i_mem_valid) begin
            rd_pending <= 1'b0;                 // Word returned
        end
    end

    // ------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------

    req_while_busy: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_busy |-> !i_req) else begin
        fail_count++;
        $error("Request strobed while the cache is busy");
    end

    second_mem_rd: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_mem_rd |-> !rd_pending) else begin
        fail_count++;
        $error("Memory read issued before the last returned");
    end

    valid_with_mem_rd: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        !(i_valid && i_mem_rd)) else begin
        fail_count++;
        $error("Read response during a memory read");
    end

    // A word arriving outside the wait state would be lost
    mem_valid_in_wait: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_mem_valid |-> (i_state == ST_FILL_WAIT)) else begin
        fail_count++;
        $error("Memory word arrived while the controller was not waiting");
    end

endmodule

// ==== verification/cache_tb.sv ====
// ------------------------------------------------------------
// Read cache testbench: clock, reset, backing memory model,
// stimulus table with response and refill checks, watchdog
// ------------------------------------------------------------

`timescale 1ns/10ps

module cache_tb
    import cache_pkg::*;
();

    localparam int DATA_WIDTH    = 32;
    localparam int TAG_WIDTH     = 8;
    localparam int INDEX_WIDTH   = 4;
    localparam int OFFSET_WIDTH  = 2;
    localparam int ADDR_WIDTH    = TAG_WIDTH + INDEX_WIDTH + OFFSET_WIDTH;
    localparam int NUM_LINES     = 2**INDEX_WIDTH;
    localparam int BLOCK_WORDS   = 2**OFFSET_WIDTH;
    localparam int CLK_PERIOD    = 4;           // ns
    localparam int RESET_CYCLES  = 3;
    localparam int MAX_MEM_DELAY = 4;           // Memory answers 1 to 4 cycles late
    localparam int NUM_ENTRIES   = 18;
    localparam int REFILL_MAX    = BLOCK_WORDS * (1 + MAX_MEM_DELAY);
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_LINES
                                  + NUM_ENTRIES * (REFILL_MAX + 4) + 20;
    localparam logic [DATA_WIDTH-1:0] FILL_PATTERN = 32'hA5C3_0F96;

    typedef struct packed {
        cache_op_e             op;
        logic [ADDR_WIDTH-1:0] addr;
        logic                  miss;            // Read expected to refill
    } stim_t;

    logic                  i_clock = 1'b0;
    logic                  i_rst_n;
    logic                  i_req;
    cache_op_e             i_op;
    logic [ADDR_WIDTH-1:0] i_addr;
    logic                  i_mem_valid;
    logic [DATA_WIDTH-1:0] i_mem_rdata;
    logic                  o_busy;
    logic                  o_valid;
    logic [DATA_WIDTH-1:0] o_rdata;
    logic                  o_mem_rd;
    logic [ADDR_WIDTH-1:0] o_mem_addr;

    stim_t                 stim_table [NUM_ENTRIES];
    logic                  ref_valid [NUM_LINES];   // Expected line state
    logic [TAG_WIDTH-1:0]  ref_tag [NUM_LINES];
    logic [ADDR_WIDTH-1:0] fetch_q [$];         // Memory reads seen since last check
    logic [DATA_WIDTH-1:0] resp_data_q [$];     // Pending reads, in request order
    int                    resp_cycle_q [$];    // Due cycle, -1 after a refill
    logic [DATA_WIDTH-1:0] exp_data;
    int                    exp_cycle;
    int                    cycle_cnt = 0;
    integer                seed = 32'h6a04_fe83;

    cache_top #(
        .DATA_WIDTH (DATA_WIDTH), .TAG_WIDTH (TAG_WIDTH),
        .INDEX_WIDTH (INDEX_WIDTH), .OFFSET_WIDTH (OFFSET_WIDTH)
    ) i_cache_top (
        .i_clock (i_clock), .i_rst_n (i_rst_n), .i_req (i_req), .i_op (i_op),
        .i_addr (i_addr), .i_mem_valid (i_mem_valid), .i_mem_rdata (i_mem_rdata),
        .o_busy (o_busy), .o_valid (o_valid), .o_rdata (o_rdata),
        .o_mem_rd (o_mem_rd), .o_mem_addr (o_mem_addr)
    );

    bind cache_top cache_chk u_chk (
        .i_clock (i_clock), .i_rst_n (i_rst_n), .i_req (i_req), .i_busy (o_busy),
        .i_valid (o_valid), .i_mem_rd (o_mem_rd), .i_mem_valid (i_mem_valid),
        .i_state (u_ctrl.state_q)
    );

    always #(CLK_PERIOD / 2) i_clock = ~i_clock;
    always @(posedge i_clock) cycle_cnt <= cycle_cnt + 1;  // Edges so far

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------

    // Every memory word is its address under a fixed mask
    function automatic logic [DATA_WIDTH-1:0] backing_word(input logic [ADDR_WIDTH-1:0] addr);
        return DATA_WIDTH'(addr) ^ FILL_PATTERN;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] make_addr(input logic [TAG_WIDTH-1:0] tag,
            input logic [INDEX_WIDTH-1:0] idx, input logic [OFFSET_WIDTH-1:0] off);
        return {tag, idx, off};
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // A miss must fetch its whole block from the base, a hit nothing
    task automatic check_fetches(input logic miss, input logic [TAG_WIDTH-1:0] tag,
            input logic [INDEX_WIDTH-1:0] idx);
        int                    exp_count;
        logic [ADDR_WIDTH-1:0] exp_addr;
        exp_count = miss ? BLOCK_WORDS : 0;
        assert (fetch_q.size() == exp_count) else
            report_failure($sformatf("[ERROR] t=%0t o_mem_rd count: expected %0d, got %0d",
                $time, exp_count, fetch_q.size()));
        for (int w = 0; w < exp_count; w++) begin
            exp_addr = {tag, idx, OFFSET_WIDTH'(w)};
            assert (fetch_q[w] == exp_addr) else
                report_failure($sformatf("[ERROR] t=%0t o_mem_addr: expected %h, got %h",
                    $time, exp_addr, fetch_q[w]));
        end
        fetch_q.delete();
    endtask

    task automatic apply_entry(input stim_t s);
        logic [TAG_WIDTH-1:0]   tag;
        logic [INDEX_WIDTH-1:0] idx;
        logic                   pred_miss;
        tag = s.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
        idx = s.addr[OFFSET_WIDTH +: INDEX_WIDTH];
        pred_miss = (s.op == OP_READ) && !(ref_valid[idx] && ref_tag[idx] == tag);
        assert (pred_miss == s.miss) else
            report_failure($sformatf("Table entry for address %h disagrees with the line model",
                s.addr));
        while (o_busy) @(negedge i_clock);
        i_req  = 1'b1;
        i_op   = s.op;
        i_addr = s.addr;
        if (s.op == OP_READ) begin
            resp_data_q.push_back(backing_word(s.addr));
            resp_cycle_q.push_back(s.miss ? -1 : cycle_cnt + 2);  // Hit latency is fixed
        end
        @(negedge i_clock);
        i_req = 1'b0;
        while (o_busy) @(negedge i_clock);     // Refill, if any, is done here
        check_fetches(s.miss, tag, idx);
        if (s.op == OP_INVAL) begin
            ref_valid[idx] = 1'b0;              // Whole line, whatever the tag
        end else begin
            ref_valid[idx] = 1'b1;
            ref_tag[idx]   = tag;
        end
    endtask

    // ------------------------------------------------------------
    // Backing memory model
    // ------------------------------------------------------------

    initial begin : backing_memory
        int                    mem_wait;
        logic [ADDR_WIDTH-1:0] pend_addr;
        mem_wait    = 0;
        pend_addr   = '0;
        i_mem_valid = 1'b0;
        i_mem_rdata = '0;
        forever begin
            @(negedge i_clock);
            i_mem_valid = 1'b0;
            if (mem_wait > 0) begin
                mem_wait--;
                if (mem_wait == 0) begin
                    i_mem_valid = 1'b1;         // Seen in ST_FILL_WAIT
                    i_mem_rdata = backing_word(pend_addr);
                end
            end else if (i_rst_n && o_mem_rd) begin
                pend_addr = o_mem_addr;
                fetch_q.push_back(o_mem_addr);
                mem_wait = 1 + int'($unsigned($random(seed)) % MAX_MEM_DELAY);
            end
        end
    end

    // Response monitor, in request order
    always @(negedge i_clock) begin
        if (i_rst_n && o_valid) begin
            assert (resp_data_q.size() > 0) else
                report_failure("A read response arrived while no read was pending");
            exp_data  = resp_data_q.pop_front();
            exp_cycle = resp_cycle_q.pop_front();
            assert (o_rdata == exp_data) else
                report_failure($sformatf("[ERROR] t=%0t o_rdata: expected %h, got %h",
                    $time, exp_data, o_rdata));
            if (exp_cycle >= 0) begin
                assert (cycle_cnt == exp_cycle) else
                    report_failure($sformatf("[ERROR] t=%0t o_valid cycle: expected %0d, got %0d",
                        $time, exp_cycle, cycle_cnt));
            end
        end
    end

    // Protocol checker status
    always @(negedge i_clock) begin
        assert (i_cache_top.u_chk.fail_count == 0) else
            report_failure("A protocol assertion on the cache ports failed");
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------

    initial begin : stimulus
        int busy_cycles;
        i_rst_n = 1'b0;
        i_req   = 1'b0;
        i_op    = OP_READ;
        i_addr  = '0;
        for (int i = 0; i < NUM_LINES; i++) begin
            ref_valid[i] = 1'b0;
            ref_tag[i]   = '0;
        end
        stim_table = '{
            '{OP_READ,  make_addr(8'h12, 4'd3, 2'd1), 1'b1},   // Cold miss
            '{OP_READ,  make_addr(8'h12, 4'd3, 2'd0), 1'b0},   // Streamed hits
            '{OP_READ,  make_addr(8'h12, 4'd3, 2'd2), 1'b0},
            '{OP_READ,  make_addr(8'h12, 4'd3, 2'd3), 1'b0},
            '{OP_READ,  make_addr(8'h12, 4'd7, 2'd2), 1'b1},
            '{OP_READ,  make_addr(8'h12, 4'd7, 2'd2), 1'b0},
            '{OP_READ,  make_addr(8'h5A, 4'd3, 2'd0), 1'b1},   // Evicts tag 12
            '{OP_READ,  make_addr(8'h5A, 4'd3, 2'd3), 1'b0},
            '{OP_READ,  make_addr(8'h12, 4'd3, 2'd1), 1'b1},   // Refetch
            '{OP_READ,  make_addr(8'h12, 4'd7, 2'd0), 1'b0},
            '{OP_INVAL, make_addr(8'h12, 4'd7, 2'd1), 1'b0},
            '{OP_READ,  make_addr(8'h12, 4'd7, 2'd3), 1'b1},
            '{OP_INVAL, make_addr(8'h5A, 4'd12, 2'd0), 1'b0},  // Line never filled
            '{OP_READ,  make_addr(8'h12, 4'd3, 2'd2), 1'b0},
            '{OP_READ,  make_addr(8'h12, 4'd7, 2'd1), 1'b0},
            '{OP_INVAL, make_addr(8'h12, 4'd3, 2'd0), 1'b0},
            '{OP_READ,  make_addr(8'h12, 4'd3, 2'd0), 1'b1},   // Right after invalidate
            '{OP_READ,  make_addr(8'h12, 4'd3, 2'd3), 1'b0}
        };
        repeat (RESET_CYCLES) @(negedge i_clock);
        assert (!o_valid && !o_mem_rd) else
            report_failure("Read response or memory read active during reset");
        i_rst_n = 1'b1;
        busy_cycles = 0;
        while (o_busy) begin
            busy_cycles++;                      // One line cleared per cycle
            @(negedge i_clock);
        end
        assert (busy_cycles == NUM_LINES) else
            report_failure($sformatf("[ERROR] t=%0t o_busy cycles: expected %0d, got %0d",
                $time, NUM_LINES, busy_cycles));
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            apply_entry(stim_table[e]);
        end
        while (resp_data_q.size() != 0) @(negedge i_clock);
        repeat (2) @(negedge i_clock);          // Room for a stray response
        $display("*** PASSED ***");
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $fatal(1, "Watchdog expired");
    end

endmodule
